//--- design/procIsaPkg.sv
// ISA field widths, opcode and funct constants, instruction word union
package procIsaPkg;

    localparam int opcodeWidth  = 5;
    localparam int regAddrWidth = 3;
    localparam int dataWidth    = 16;
    localparam int immWidth     = 5;
    localparam int functWidth   = 2;

    // Opcodes, anything else is illegal
    localparam logic [opcodeWidth-1:0] opHalt = 5'b00000;
    localparam logic [opcodeWidth-1:0] opNop  = 5'b00001;
    localparam logic [opcodeWidth-1:0] opAddi = 5'b01000;
    localparam logic [opcodeWidth-1:0] opXori = 5'b01010;
    localparam logic [opcodeWidth-1:0] opAluR = 5'b11011;

    // Operation select inside opAluR
    localparam logic [functWidth-1:0] functAdd = 2'b00;
    localparam logic [functWidth-1:0] functSub = 2'b01;
    localparam logic [functWidth-1:0] functXor = 2'b10;
    localparam logic [functWidth-1:0] functAnd = 2'b11;

    // Register format, rd gets rs op rt (sub is rs minus rt)
    typedef struct packed {
        logic [opcodeWidth-1:0]  opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [functWidth-1:0]   funct;
    } rFmt_t;

    // Immediate format, rd gets rs op imm
    typedef struct packed {
        logic [opcodeWidth-1:0]  opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rd;
        logic [immWidth-1:0]     imm;
    } iFmt_t;

    // Same 16-bit word, two field layouts
    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
    } instrWord_t;

endpackage

//--- design/procPipePkg.sv
// Queue depth, ALU operation encoding and pipeline control struct
package procPipePkg;

    // Instruction queue entries, equal to the sender's starting credit
    localparam int queueDepth    = 4;
    localparam int queuePtrWidth = $clog2(queueDepth);

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluAnd
    } aluOp_t;

    // Control bits carried from decode down to result
    typedef struct packed {
        aluOp_t aluOp;
        logic   useImm;
        logic   regWrite;
        logic   halt;
        logic   illegal;
    } issueCtrl_t;

endpackage

//--- design/stageIf.sv
// Stage interface for operand issue and register writeback, with modports
interface stageIf;

    logic                                valid;
    procPipePkg::issueCtrl_t             ctrl;
    logic [procIsaPkg::dataWidth-1:0]    rsVal;
    logic [procIsaPkg::dataWidth-1:0]    rtVal;
    logic [procIsaPkg::regAddrWidth-1:0] rsAddr;
    logic [procIsaPkg::regAddrWidth-1:0] rtAddr;
    logic [procIsaPkg::regAddrWidth-1:0] rdAddr;

    // Writeback side
    logic [procIsaPkg::regAddrWidth-1:0] regAddr;
    logic [procIsaPkg::dataWidth-1:0]    data;

    // No ready signal, execute always accepts
    modport issueSrc (output valid, ctrl, rsVal, rtVal, rsAddr, rtAddr, rdAddr);
    modport issueDst (input valid, ctrl, rsVal, rtVal, rsAddr, rtAddr, rdAddr);

    modport wbSrc (output valid, regAddr, data);
    modport wbDst (input valid, regAddr, data);

endinterface

//--- design/decode.sv
// Credited instruction queue, decoder, register file and operand issue
module decode (
    input  logic        clk,
    input  logic        rstN,
    input  logic        insValid,
    input  logic [15:0] insWord,
    output logic        credit,
    stageIf.issueSrc    issue,
    stageIf.wbDst       wb
);

    logic [15:0]                           queueMem [procPipePkg::queueDepth];
    logic [procPipePkg::queuePtrWidth-1:0] wrPtr;
    logic [procPipePkg::queuePtrWidth-1:0] rdPtr;
    logic [procPipePkg::queuePtrWidth:0]   count;
    logic                                  haltSeen;
    logic                                  pop;

    procIsaPkg::instrWord_t                head;
    procPipePkg::issueCtrl_t               ctrl;
    logic [procIsaPkg::dataWidth-1:0]      regFile [2**procIsaPkg::regAddrWidth];
    logic [procIsaPkg::dataWidth-1:0]      rsRead;
    logic [procIsaPkg::dataWidth-1:0]      rtRead;
    logic [procIsaPkg::dataWidth-1:0]      immExt;

    assign head   = queueMem[rdPtr];
    // One pop per cycle until a HALT has gone out
    assign pop    = (count != '0) && !haltSeen;
    assign credit = pop;

    always_ff @(posedge clk) begin
        if (insValid) begin
            queueMem[wrPtr] <= insWord;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            haltSeen <= 1'b0;
        end else begin
            if (insValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Sender never pushes without credit, so no full check
            if (insValid && !pop) begin
                count <= count + 1'b1;
            end else if (!insValid && pop) begin
                count <= count - 1'b1;
            end
            if (pop && ctrl.halt) begin
                haltSeen <= 1'b1;
            end
        end
    end

    // Opcode decode
    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = procPipePkg::aluAdd;
        immExt     = {{(procIsaPkg::dataWidth - procIsaPkg::immWidth)
                       {head.iFmt.imm[procIsaPkg::immWidth-1]}}, head.iFmt.imm};
        case (head.rFmt.opcode)
            procIsaPkg::opNop:  ctrl.regWrite = 1'b0;
            procIsaPkg::opHalt: ctrl.halt = 1'b1;
            procIsaPkg::opAluR: begin
                ctrl.regWrite = 1'b1;
                case (head.rFmt.funct)
                    procIsaPkg::functAdd: ctrl.aluOp = procPipePkg::aluAdd;
                    procIsaPkg::functSub: ctrl.aluOp = procPipePkg::aluSub;
                    procIsaPkg::functXor: ctrl.aluOp = procPipePkg::aluXor;
                    procIsaPkg::functAnd: ctrl.aluOp = procPipePkg::aluAnd;
                endcase
            end
            procIsaPkg::opAddi: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            procIsaPkg::opXori: begin
                ctrl.aluOp    = procPipePkg::aluXor;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                // xori takes the immediate unsigned
                immExt = {{(procIsaPkg::dataWidth - procIsaPkg::immWidth){1'b0}},
                          head.iFmt.imm};
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

    // Register read
    // Execute forwards any write landing this cycle
    always_comb begin
        rsRead = regFile[head.rFmt.rs];
        rtRead = regFile[head.rFmt.rt];
    end

    always_ff @(posedge clk) begin
        if (wb.valid) begin
            regFile[wb.regAddr] <= wb.data;
        end
    end

    assign issue.valid  = pop;
    assign issue.ctrl   = ctrl;
    assign issue.rsVal  = rsRead;
    assign issue.rtVal  = ctrl.useImm ? immExt : rtRead;
    assign issue.rsAddr = head.rFmt.rs;
    assign issue.rtAddr = head.rFmt.rt;
    assign issue.rdAddr = ctrl.useImm ? head.iFmt.rd : head.rFmt.rd;

endmodule

//--- design/execute.sv
// Operand forwarding, ALU and execute stage register
module execute (
    input  logic                    clk,
    input  logic                    rstN,
    stageIf.issueDst                issue,
    stageIf.wbDst                   wb,
    output procPipePkg::issueCtrl_t exCtrl,
    output logic                    exValid,
    output logic [2:0]              exRd,
    output logic [15:0]             exData
);

    logic        exHit;
    logic [15:0] opA;
    logic [15:0] opB;
    logic [15:0] aluOut;

    // Stage register holds a pending write
    assign exHit = exValid && exCtrl.regWrite;

    // Newest value first: own stage register, then writeback
    always_comb begin
        opA = issue.rsVal;
        if (exHit && exRd == issue.rsAddr) begin
            opA = exData;
        end else if (wb.valid && wb.regAddr == issue.rsAddr) begin
            opA = wb.data;
        end
    end

    // rtVal already carries the immediate when useImm is set
    always_comb begin
        opB = issue.rtVal;
        if (!issue.ctrl.useImm) begin
            if (exHit && exRd == issue.rtAddr) begin
                opB = exData;
            end else if (wb.valid && wb.regAddr == issue.rtAddr) begin
                opB = wb.data;
            end
        end
    end

    always_comb begin
        unique case (issue.ctrl.aluOp)
            procPipePkg::aluAdd: aluOut = opA + opB;
            procPipePkg::aluSub: aluOut = opA - opB;
            procPipePkg::aluXor: aluOut = opA ^ opB;
            procPipePkg::aluAnd: aluOut = opA & opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= issue.valid;
        end
    end

    // Payload, qualified by exValid downstream
    always_ff @(posedge clk) begin
        exCtrl <= issue.ctrl;
        exRd   <= issue.rdAddr;
        exData <= aluOut;
    end

endmodule

//--- design/result.sv
// Result stage register, register file write, retire ports, sticky halt and error
module result (
    input  logic                    clk,
    input  logic                    rstN,
    input  procPipePkg::issueCtrl_t exCtrl,
    input  logic                    exValid,
    input  logic [2:0]              exRd,
    input  logic [15:0]             exData,
    stageIf.wbSrc                   wb,
    output logic                    wbValid,
    output logic [2:0]              wbReg,
    output logic [15:0]             wbData,
    output logic                    halted,
    output logic                    err
);

    logic retire;

    // Only register-writing instructions retire on the ports
    assign retire = exValid && exCtrl.regWrite;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            halted  <= 1'b0;
            err     <= 1'b0;
        end else begin
            wbValid <= retire;
            // Both flags hold until reset
            if (exValid && exCtrl.halt) begin
                halted <= 1'b1;
            end
            if (exValid && exCtrl.illegal) begin
                err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            wbReg  <= exRd;
            wbData <= exData;
        end
    end

    // Register file write and second forwarding source
    assign wb.valid   = wbValid;
    assign wb.regAddr = wbReg;
    assign wb.data    = wbData;

endmodule

//--- design/proc.sv
// Processor top level joining the decode, execute and result stages
module proc (
    input  logic        clk,
    input  logic        rstN,
    input  logic        insValid,
    input  logic [15:0] insWord,
    output logic        credit,
    output logic        wbValid,
    output logic [2:0]  wbReg,
    output logic [15:0] wbData,
    output logic        halted,
    output logic        err
);

    // Decode to execute
    stageIf issueBus ();
    // Result back to decode and execute
    stageIf wbBus ();

    procPipePkg::issueCtrl_t exCtrl;
    logic                    exValid;
    logic [2:0]              exRd;
    logic [15:0]             exData;

    decode decode0 (
        .clk      (clk),
        .rstN     (rstN),
        .insValid (insValid),
        .insWord  (insWord),
        .credit   (credit),
        .issue    (issueBus.issueSrc),
        .wb       (wbBus.wbDst)
    );

    execute exec0 (
        .clk     (clk),
        .rstN    (rstN),
        .issue   (issueBus.issueDst),
        .wb      (wbBus.wbDst),
        .exCtrl  (exCtrl),
        .exValid (exValid),
        .exRd    (exRd),
        .exData  (exData)
    );

    result result0 (
        .clk     (clk),
        .rstN    (rstN),
        .exCtrl  (exCtrl),
        .exValid (exValid),
        .exRd    (exRd),
        .exData  (exData),
        .wb      (wbBus.wbSrc),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .halted  (halted),
        .err     (err)
    );

endmodule

//--- bench/tbClock.sv
// Free-running clock and power-on reset for the testbench
module tbClock (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    localparam int halfPeriod  = 20;
    localparam int resetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2 rstN = 1'b1;
    end

endmodule

//--- bench/procChecker.sv
// Reference ISA model, DUT port watcher, write comparisons and test reports
module procChecker (
    input logic        clk,
    input logic        rstN,
    input logic        insValid,
    input logic [15:0] insWord,
    input logic        credit,
    input logic        wbValid,
    input logic [2:0]  wbReg,
    input logic [15:0] wbData,
    input logic        halted,
    input logic        err
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] kindNone    = 2'd0;
    localparam logic [1:0] kindWrite   = 2'd1;
    localparam logic [1:0] kindHalt    = 2'd2;
    localparam logic [1:0] kindIllegal = 2'd3;

    logic [15:0] refRegs [8];
    logic [2:0]  expRd [$];
    logic [15:0] expData [$];
    int          pending = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          testErrors = 0;
    int          accepted = 0;
    int          returned = 0;
    int          acceptedToHalt = 0;
    int          cycle = 0;
    int          firstAccept = 0;
    bit          refHalted = 1'b0;
    bit          errExpected = 1'b0;
    bit          resetChecked = 1'b0;
    bit          firstWbDone = 1'b0;

    // Starting register contents, distinct for every address
    function automatic logic [15:0] regFill(input int idx);
        return 16'h3c5a ^ (16'h0f13 * (idx + 1));
    endfunction

    // Returns {kind, rd, value} for one instruction against refRegs
    function automatic logic [20:0] refExecute(input procIsaPkg::instrWord_t w);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [2:0]  rd;
        logic [1:0]  kind;
        a    = refRegs[w.rFmt.rs];
        b    = refRegs[w.rFmt.rt];
        res  = '0;
        rd   = w.rFmt.rd;
        kind = kindWrite;
        case (w.rFmt.opcode)
            procIsaPkg::opNop:  kind = kindNone;
            procIsaPkg::opHalt: kind = kindHalt;
            procIsaPkg::opAluR: begin
                case (w.rFmt.funct)
                    procIsaPkg::functAdd: res = a + b;
                    procIsaPkg::functSub: res = a - b;
                    procIsaPkg::functXor: res = a ^ b;
                    default:              res = a & b;
                endcase
            end
            procIsaPkg::opAddi: begin
                rd  = w.iFmt.rd;
                res = a + {{11{w.iFmt.imm[4]}}, w.iFmt.imm};
            end
            procIsaPkg::opXori: begin
                rd  = w.iFmt.rd;
                res = a ^ {11'b0, w.iFmt.imm};
            end
            default: kind = kindIllegal;
        endcase
        return {kind, rd, res};
    endfunction

    task automatic compareValue(input string sigName, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("CHECK FAILED at time %0t: %s expected %0h got %0h",
                     $time, sigName, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        testErrors++;
        $display("Error at time %0t: %s", $time, what);
    endtask

    task automatic acceptWord(input logic [15:0] word);
        logic [20:0] r;
        if (accepted == 0) begin
            firstAccept = cycle;
        end
        accepted++;
        // Nothing after a HALT ever executes
        if (!refHalted) begin
            r = refExecute(word);
            case (r[20:19])
                kindWrite: begin
                    refRegs[r[18:16]] = r[15:0];
                    expRd.push_back(r[18:16]);
                    expData.push_back(r[15:0]);
                end
                kindHalt: begin
                    refHalted      = 1'b1;
                    acceptedToHalt = accepted;
                end
                kindIllegal: errExpected = 1'b1;
                default: ;
            endcase
        end
        pending = expData.size();
    endtask

    task automatic reportTest(input string name);
        compareValue("halted", refHalted, halted);
        compareValue("err", errExpected, err);
        compareValue("credits returned", refHalted ? acceptedToHalt : accepted, returned);
        testCount++;
        $display("Test %0d %s finished with %0d errors", testCount, name, testErrors);
        testErrors = 0;
    endtask

    initial begin
        for (int i = 0; i < 8; i++) begin
            refRegs[i] = regFill(i);
        end
    end

    // Mid-cycle sampling, inputs and outputs are settled here
    always @(negedge clk) begin
        if (rstN) begin
            cycle++;
            if (!resetChecked) begin
                resetChecked = 1'b1;
                compareValue("credit", 0, credit);
                compareValue("wbValid", 0, wbValid);
                compareValue("halted", 0, halted);
                compareValue("err", 0, err);
            end
            if (credit) begin
                returned++;
                if (returned > accepted) begin
                    reportProblem("credit returned for an instruction never accepted");
                end else if (returned == 1) begin
                    compareValue("credit cycle", firstAccept + 1, cycle);
                end
            end
            if (wbValid) begin
                if (expData.size() == 0) begin
                    reportProblem($sformatf("write to r%0d with no write expected", wbReg));
                end else begin
                    if (!firstWbDone) begin
                        firstWbDone = 1'b1;
                        compareValue("wbValid cycle", firstAccept + 3, cycle);
                    end
                    compareValue("wbReg", expRd.pop_front(), wbReg);
                    compareValue("wbData", expData.pop_front(), wbData);
                end
                pending = expData.size();
            end
            if (insValid) begin
                acceptWord(insWord);
            end
        end
    end

endmodule

//--- bench/procTb.sv
// Testbench top with the DUT, credited stimulus, random streams and watchdog
module procTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numAlu     = 48;
    localparam int numImm     = 30;
    localparam int numMixed   = 16;
    // Directed words of the first and last tests included
    localparam int totalInstr = 4 + numAlu + numImm + numMixed + 5;
    localparam int clkPeriod  = 40;

    logic        clk;
    logic        rstN;
    logic        insValid;
    logic [15:0] insWord;
    logic        credit;
    logic        wbValid;
    logic [2:0]  wbReg;
    logic [15:0] wbData;
    logic        halted;
    logic        err;
    int          credits;
    int unsigned seed;

    tbClock clkGen (
        .clk  (clk),
        .rstN (rstN)
    );

    proc proc_inst (
        .clk      (clk),
        .rstN     (rstN),
        .insValid (insValid),
        .insWord  (insWord),
        .credit   (credit),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .halted   (halted),
        .err      (err)
    );

    procChecker checker0 (
        .clk      (clk),
        .rstN     (rstN),
        .insValid (insValid),
        .insWord  (insWord),
        .credit   (credit),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .halted   (halted),
        .err      (err)
    );

    function automatic logic [15:0] aluWord(input logic [1:0] funct, input int rs,
                                            input int rt, input int rd);
        procIsaPkg::instrWord_t w;
        w.rFmt.opcode = procIsaPkg::opAluR;
        w.rFmt.rs     = rs[2:0];
        w.rFmt.rt     = rt[2:0];
        w.rFmt.rd     = rd[2:0];
        w.rFmt.funct  = funct;
        return w;
    endfunction

    function automatic logic [15:0] immWord(input logic [4:0] op, input int rs,
                                            input int rd, input int imm);
        procIsaPkg::instrWord_t w;
        w.iFmt.opcode = op;
        w.iFmt.rs     = rs[2:0];
        w.iFmt.rd     = rd[2:0];
        w.iFmt.imm    = imm[4:0];
        return w;
    endfunction

    // Mode 0 ALU only on r0-r3, mode 1 immediates and NOPs, mode 2 a mix
    function automatic logic [15:0] randomWord(input int mode);
        int          pick;
        logic [10:0] junk;
        pick = $urandom % 4;
        junk = $urandom;
        if (mode == 0 || (mode == 2 && pick < 2)) begin
            return aluWord($urandom % 4, $urandom % 4, $urandom % 4, $urandom % 4);
        end
        if (pick == 0) begin
            return {procIsaPkg::opNop, junk};
        end
        return immWord(pick[0] ? procIsaPkg::opAddi : procIsaPkg::opXori,
                       $urandom % 8, $urandom % 8, $urandom % 32);
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic sendWord(input logic [15:0] w);
        while (credits == 0) begin
            insValid = 1'b0;
            stepCycle();
        end
        insValid = 1'b1;
        insWord  = w;
        credits  = credits - 1;
        stepCycle();
    endtask

    task automatic drain(input bit waitCredits);
        insValid = 1'b0;
        while ((waitCredits && credits != procPipePkg::queueDepth) ||
               checker0.pending != 0) begin
            stepCycle();
        end
        repeat (4) stepCycle();
    endtask

    task automatic runStream(input string name, input int count, input int mode);
        for (int i = 0; i < count; i++) begin
            // Mixed stream leaves random idle gaps
            if (mode == 2 && $urandom % 3 == 0) begin
                insValid = 1'b0;
                stepCycle();
            end
            sendWord(randomWord(mode));
        end
        drain(1'b1);
        checker0.reportTest(name);
    endtask

    always @(negedge clk) begin
        if (rstN && credit) begin
            credits = credits + 1;
        end
    end

    initial begin
        insValid = 1'b0;
        insWord  = '0;
        credits  = procPipePkg::queueDepth;
        seed     = 32'h4c84_6067;
        void'($urandom(seed));
        // Register file has no reset, load known contents
        for (int i = 0; i < 8; i++) begin
            proc_inst.decode0.regFile[i] = checker0.regFill(i);
        end
        wait (rstN === 1'b1);
        stepCycle();
        sendWord(immWord(procIsaPkg::opXori, 0, 2, 5'h1f));
        sendWord(immWord(procIsaPkg::opAddi, 1, 1, 5'h1d));
        sendWord(aluWord(procIsaPkg::functAdd, 1, 2, 3));
        sendWord(aluWord(procIsaPkg::functAnd, 3, 1, 4));
        drain(1'b1);
        checker0.reportTest("reset and latency");
        runStream("aluForward", numAlu, 0);
        runStream("immediate", numImm, 1);
        runStream("credits", numMixed, 2);
        // Illegal opcode, then HALT with two words behind it
        sendWord({5'b10101, 11'h2a3});
        sendWord(aluWord(procIsaPkg::functSub, 0, 1, 5));
        sendWord({procIsaPkg::opHalt, 11'h000});
        sendWord(immWord(procIsaPkg::opAddi, 5, 6, 3));
        sendWord(immWord(procIsaPkg::opXori, 6, 7, 9));
        drain(1'b0);
        checker0.reportTest("illegalHalt");
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 checker0.testCount, checker0.checkCount, checker0.errorCount);
        if (checker0.errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #((totalInstr + 50) * clkPeriod * 4);
        $display("Timeout: run still busy after %0d cycles", (totalInstr + 50) * 4);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- build.f
design/procIsaPkg.sv
design/procPipePkg.sv
design/stageIf.sv
design/decode.sv
design/execute.sv
design/result.sv
design/proc.sv
bench/tbClock.sv
bench/procChecker.sv
bench/procTb.sv
